// File: common/ethApbPkg.sv
////////////////////
// Ethernet MAC host interface constants
// Bus widths, APB address windows, register map and reset values
////////////////////
package ethApbPkg;

  ////////////////////
  // Bus widths
  ////////////////////
  localparam int DataWidth    = 32;          // APB data bus
  localparam int AddrWidth    = 32;          // APB address bus
  localparam int WordIdxWidth = 8;           // Word index, address bits 9..2
  localparam int IdxLsb       = 2;           // Byte offset bits below the index

  ////////////////////
  // Address windows
  ////////////////////
  // 0x000-0x3FF registers, 0x400-0x7FF descriptors, 0x800-0xFFF miss
  localparam int WinBitHi = 11;              // Set for the miss window
  localparam int WinBitLo = 10;              // Registers vs descriptors

  ////////////////////
  // Register word indices
  ////////////////////
  localparam logic [WordIdxWidth-1:0] ModerIdx    = 8'h00;  // Offset 0x00
  localparam logic [WordIdxWidth-1:0] TxBdNumIdx  = 8'h08;  // Offset 0x20
  localparam logic [WordIdxWidth-1:0] MacAddr0Idx = 8'h10;  // Offset 0x40
  localparam logic [WordIdxWidth-1:0] MacAddr1Idx = 8'h11;  // Offset 0x44
  localparam logic [WordIdxWidth-1:0] Hash0Idx    = 8'h12;  // Offset 0x48
  localparam logic [WordIdxWidth-1:0] Hash1Idx    = 8'h13;  // Offset 0x4C

  ////////////////////
  // Register values and write masks
  ////////////////////
  // Mode register comes up with PAD and CRCEN set
  localparam logic [DataWidth-1:0] ModerReset = 32'h0000_A000;

  // Only the low 17 mode bits exist
  localparam logic [DataWidth-1:0] ModerMask = 32'h0001_FFFF;

  // Half of the 128 descriptors go to transmit by default
  localparam logic [DataWidth-1:0] TxBdNumReset = 32'h0000_0040;
  localparam logic [DataWidth-1:0] TxBdNumMax   = 32'h0000_0080;

  // Upper MAC address register holds bytes 0 and 1 only
  localparam logic [DataWidth-1:0] MacAddr1Mask = 32'h0000_FFFF;

  ////////////////////
  // Descriptor memory
  ////////////////////
  localparam int BdWords = 256;              // One word per index value

endpackage

// File: common/ethRegAccessIf.sv
////////////////////
// Decoded word access
// One APB access phase routed to a single target
////////////////////
`timescale 1ns/1ps

interface ethRegAccessIf;

  logic                                 sel;    // Access phase, in window
  logic                                 write;  // High for a write
  logic [ethApbPkg::WordIdxWidth-1:0]   idx;    // Word index
  logic [ethApbPkg::DataWidth-1:0]      wdata;
  logic [ethApbPkg::DataWidth-1:0]      rdata;  // Valid with ready on a read
  logic                                 ready;  // Access ends this cycle

  // Decoder side
  modport master (
    output sel,
    output write,
    output idx,
    output wdata,
    input  rdata,
    input  ready
  );

  // Register file and descriptor memory side
  modport target (
    input  sel,
    input  write,
    input  idx,
    input  wdata,
    output rdata,
    output ready
  );

endinterface

// File: rtl/ethRegFile/ethRegFile.sv
////////////////////
// Ethernet configuration registers
// Mode, descriptor count, MAC address and hash table with their
// reset values and write rules, zero wait states
////////////////////
`timescale 1ns/1ps

module ethRegFile (
  input  logic           pclk_i,
  input  logic           prstn_i,
  ethRegAccessIf.target  acc
);

  logic [ethApbPkg::DataWidth-1:0] moderQ;     // MODER
  logic [ethApbPkg::DataWidth-1:0] txBdNumQ;   // TX_BD_NUM
  logic [ethApbPkg::DataWidth-1:0] macAddr0Q;  // MAC bytes 2..5
  logic [ethApbPkg::DataWidth-1:0] macAddr1Q;  // MAC bytes 0..1
  logic [ethApbPkg::DataWidth-1:0] hash0Q;
  logic [ethApbPkg::DataWidth-1:0] hash1Q;

  logic wrEn;
  logic txBdNumOk;

  assign wrEn = acc.sel & acc.write;

  // Counts above the descriptor total are dropped
  assign txBdNumOk = (acc.wdata <= ethApbPkg::TxBdNumMax);

  ////////////////////
  // Register writes
  ////////////////////
  always_ff @(posedge pclk_i or negedge prstn_i)
  begin
    if (!prstn_i)
    begin
      moderQ    <= ethApbPkg::ModerReset;
      txBdNumQ  <= ethApbPkg::TxBdNumReset;
      macAddr0Q <= '0;
      macAddr1Q <= '0;
      hash0Q    <= '0;
      hash1Q    <= '0;
    end
    else if (wrEn)
    begin
      case (acc.idx)
        ethApbPkg::ModerIdx:
        begin
          moderQ <= acc.wdata & ethApbPkg::ModerMask;
        end
        ethApbPkg::TxBdNumIdx:
        begin
          if (txBdNumOk)
            txBdNumQ <= acc.wdata;   // Old value kept otherwise
        end
        ethApbPkg::MacAddr0Idx:
        begin
          macAddr0Q <= acc.wdata;
        end
        ethApbPkg::MacAddr1Idx:
        begin
          macAddr1Q <= acc.wdata & ethApbPkg::MacAddr1Mask;
        end
        ethApbPkg::Hash0Idx:
        begin
          hash0Q <= acc.wdata;
        end
        ethApbPkg::Hash1Idx:
        begin
          hash1Q <= acc.wdata;
        end
        default:
        begin
          // Unmapped word, write is dropped
        end
      endcase
    end
  end

  ////////////////////
  // Read mux
  ////////////////////
  always_comb
  begin
    case (acc.idx)
      ethApbPkg::ModerIdx:    acc.rdata = moderQ;
      ethApbPkg::TxBdNumIdx:  acc.rdata = txBdNumQ;
      ethApbPkg::MacAddr0Idx: acc.rdata = macAddr0Q;
      ethApbPkg::MacAddr1Idx: acc.rdata = macAddr1Q;
      ethApbPkg::Hash0Idx:    acc.rdata = hash0Q;
      ethApbPkg::Hash1Idx:    acc.rdata = hash1Q;
      default:                acc.rdata = '0;   // Unmapped reads zero
    endcase
  end

  // No wait states, every access ends in its first cycle
  assign acc.ready = acc.sel;

endmodule

// File: rtl/ethBdMem/ethBdMem.sv
////////////////////
// Buffer-descriptor memory
// Word array behind the 0x400 window, one wait state per access
////////////////////
`timescale 1ns/1ps

module ethBdMem (
  input  logic           pclk_i,
  input  logic           prstn_i,
  ethRegAccessIf.target  acc
);

  logic [ethApbPkg::DataWidth-1:0] bdMem [ethApbPkg::BdWords];

  logic                            readyQ;
  logic [ethApbPkg::DataWidth-1:0] rdataQ;
  logic                            firstCycle;   // First access cycle of a transfer

  // The ready pulse marks the second cycle, so nothing restarts there
  assign firstCycle = acc.sel & ~readyQ;

  ////////////////////
  // Ready generation
  ////////////////////
  always_ff @(posedge pclk_i or negedge prstn_i)
  begin
    if (!prstn_i)
    begin
      readyQ <= 1'b0;
    end
    else
    begin
      readyQ <= firstCycle;   // High for exactly one cycle
    end
  end

  ////////////////////
  // Storage
  ////////////////////
  always_ff @(posedge pclk_i)
  begin
    if (firstCycle & acc.write)
    begin
      bdMem[acc.idx] <= acc.wdata;
    end
  end

  // Read data is registered and shows up together with ready
  always_ff @(posedge pclk_i)
  begin
    if (firstCycle & ~acc.write)
    begin
      rdataQ <= bdMem[acc.idx];
    end
  end

  assign acc.ready = readyQ;
  assign acc.rdata = rdataQ;

endmodule

// File: rtl/ethApbDecode.sv
////////////////////
// APB window decoder
// Routes each access to registers or descriptors, merges the
// responses and answers the miss window with an error
////////////////////
`timescale 1ns/1ps

module ethApbDecode (
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [ethApbPkg::AddrWidth-1:0]  paddr_i,
  input  logic [ethApbPkg::DataWidth-1:0]  pwdata_i,
  output logic [ethApbPkg::DataWidth-1:0]  prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  ethRegAccessIf.master                    regAcc,
  ethRegAccessIf.master                    bdAcc
);

  logic accessPhase;   // psel and penable both high
  logic inRegWin;
  logic inBdWin;
  logic inMissWin;
  logic missSel;
  logic readDone;      // A read completes this cycle

  logic [ethApbPkg::WordIdxWidth-1:0] wordIdx;

  ////////////////////
  // Address classification
  ////////////////////
  assign accessPhase = psel_i & penable_i;

  assign inMissWin = paddr_i[ethApbPkg::WinBitHi];                      // 0x800-0xFFF
  assign inBdWin   = ~paddr_i[ethApbPkg::WinBitHi] & paddr_i[ethApbPkg::WinBitLo];
  assign inRegWin  = ~paddr_i[ethApbPkg::WinBitHi] & ~paddr_i[ethApbPkg::WinBitLo];

  assign wordIdx = paddr_i[ethApbPkg::IdxLsb +: ethApbPkg::WordIdxWidth];

  ////////////////////
  // Target requests
  ////////////////////
  // Both targets see the same index and data, only sel differs
  assign regAcc.sel   = accessPhase & inRegWin;
  assign regAcc.write = pwrite_i;
  assign regAcc.idx   = wordIdx;
  assign regAcc.wdata = pwdata_i;

  assign bdAcc.sel    = accessPhase & inBdWin;
  assign bdAcc.write  = pwrite_i;
  assign bdAcc.idx    = wordIdx;
  assign bdAcc.wdata  = pwdata_i;

  // Nothing lives here, so complete at once with an error
  assign missSel = accessPhase & inMissWin;

  ////////////////////
  // APB response
  ////////////////////
  assign pready_o  = (regAcc.sel & regAcc.ready) | (bdAcc.sel & bdAcc.ready) | missSel;
  assign pslverr_o = missSel;

  assign readDone = pready_o & ~pwrite_i;

  // Read data is zero except in the cycle a read completes
  always_comb
  begin
    prdata_o = '0;
    if (readDone)
    begin
      if (regAcc.sel)
        prdata_o = regAcc.rdata;
      else if (bdAcc.sel)
        prdata_o = bdAcc.rdata;
    end
  end

endmodule

// File: rtl/ethApbTop.sv
////////////////////
// Ethernet MAC APB slave
// Decoder, configuration registers and descriptor memory
////////////////////
`timescale 1ns/1ps

module ethApbTop (
  input  logic                             pclk_i,
  input  logic                             prstn_i,
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [ethApbPkg::AddrWidth-1:0]  paddr_i,
  input  logic [ethApbPkg::DataWidth-1:0]  pwdata_i,
  output logic [ethApbPkg::DataWidth-1:0]  prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o
);

  ethRegAccessIf regAcc ();   // Register window
  ethRegAccessIf bdAcc ();    // Descriptor window

  // Window decode and response merge
  ethApbDecode i_ethApbDecode (
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .regAcc    (regAcc),
    .bdAcc     (bdAcc)
  );

  ethRegFile i_ethRegFile (
    .pclk_i  (pclk_i),
    .prstn_i (prstn_i),
    .acc     (regAcc)
  );

  ethBdMem i_ethBdMem (
    .pclk_i  (pclk_i),
    .prstn_i (prstn_i),
    .acc     (bdAcc)
  );

endmodule

// File: tb/tbClkGen.sv
////////////////////
// Testbench clock and reset
// 8 ns clock, reset low for the first 4 cycles
////////////////////
`timescale 1ns/1ps

module tbClkGen (
  output logic clk_o,
  output logic rstn_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;   // 8 ns period
  end

  // Release after the fourth rising edge
  initial
  begin
    rstn_o = 1'b0;
    repeat (4) @(posedge clk_o);
    rstn_o <= 1'b1;
  end

endmodule

// File: tb/ethApbAsserts.sv
////////////////////
// APB slave protocol checks
// Response timing per address window, bound into the DUT
////////////////////
`timescale 1ns/1ps

module ethApbAsserts (
  input logic                            pclk_i,
  input logic                            prstn_i,
  input logic                            psel_i,
  input logic                            penable_i,
  input logic                            pwrite_i,
  input logic [ethApbPkg::AddrWidth-1:0] paddr_i,
  input logic [ethApbPkg::DataWidth-1:0] prdata_i,
  input logic                            pready_i,
  input logic                            pslverr_i
);

  logic setupPhase;
  logic accessPhase;
  logic regWin;
  logic bdWin;
  logic missWin;

  assign setupPhase  = psel_i & ~penable_i;
  assign accessPhase = psel_i & penable_i;
  assign missWin     = paddr_i[ethApbPkg::WinBitHi];
  assign bdWin       = ~paddr_i[ethApbPkg::WinBitHi] & paddr_i[ethApbPkg::WinBitLo];
  assign regWin      = ~paddr_i[ethApbPkg::WinBitHi] & ~paddr_i[ethApbPkg::WinBitLo];

  ////////////////////
  // Response gating
  ////////////////////
  idleQuiet: assert property (@(posedge pclk_i) disable iff (!prstn_i)
    !accessPhase |-> (!pready_i && !pslverr_i))
    else $error("pready or pslverr high outside an access phase");

  errOnlyInMiss: assert property (@(posedge pclk_i) disable iff (!prstn_i)
    pslverr_i |-> missWin)
    else $error("pslverr high for an address outside the miss window");

  writeDataZero: assert property (@(posedge pclk_i) disable iff (!prstn_i)
    (accessPhase && pwrite_i) |-> (prdata_i == '0))
    else $error("prdata not zero during a write");

  ////////////////////
  // Window timing
  ////////////////////
  regNoWait: assert property (@(posedge pclk_i) disable iff (!prstn_i)
    (accessPhase && regWin) |-> (pready_i && !pslverr_i))
    else $error("Register access did not complete in its first access cycle");

  bdFirstWait: assert property (@(posedge pclk_i) disable iff (!prstn_i)
    (accessPhase && bdWin && $past(setupPhase)) |-> !pready_i)
    else $error("Descriptor access completed without a wait state");

  bdSecondReady: assert property (@(posedge pclk_i) disable iff (!prstn_i)
    (accessPhase && bdWin && $past(accessPhase)) |-> pready_i)
    else $error("Descriptor access not ready in its second access cycle");

  missError: assert property (@(posedge pclk_i) disable iff (!prstn_i)
    (accessPhase && missWin) |-> (pready_i && pslverr_i && prdata_i == '0))
    else $error("Miss window access without an immediate error response");

endmodule

bind ethApbTop ethApbAsserts i_ethApbAsserts (
  .pclk_i    (pclk_i),
  .prstn_i   (prstn_i),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pwrite_i  (pwrite_i),
  .paddr_i   (paddr_i),
  .prdata_i  (prdata_o),
  .pready_i  (pready_o),
  .pslverr_i (pslverr_o)
);

// File: tb/tbEthApbTop.sv
////////////////////
// Ethernet APB slave testbench
// Shadow-model stimulus with a read-data assertion
////////////////////
`timescale 1ns/1ps

module tbEthApbTop;

  logic                               pclk;
  logic                               prstn;
  logic                               psel;
  logic                               penable;
  logic                               pwrite;
  logic [ethApbPkg::AddrWidth-1:0]    paddr;
  logic [ethApbPkg::DataWidth-1:0]    pwdata;
  logic [ethApbPkg::DataWidth-1:0]    prdata;
  logic                               pready;
  logic                               pslverr;
  logic [ethApbPkg::DataWidth-1:0]    expData;     // Expected data of the current read
  int unsigned                        cycleCount = 0;

  // Mapped registers only, absent keys read as zero
  logic [ethApbPkg::DataWidth-1:0]    shadowReg [logic [ethApbPkg::WordIdxWidth-1:0]];
  logic [ethApbPkg::DataWidth-1:0]    shadowBd [ethApbPkg::BdWords];
  logic [ethApbPkg::WordIdxWidth-1:0] bdTouched [$];
  logic [ethApbPkg::WordIdxWidth-1:0] rwList [6] = '{ethApbPkg::ModerIdx,
    ethApbPkg::MacAddr0Idx, ethApbPkg::MacAddr1Idx, ethApbPkg::Hash0Idx,
    ethApbPkg::Hash1Idx, 8'h05};

  tbClkGen i_tbClkGen (.clk_o(pclk), .rstn_o(prstn));

  ethApbTop i_ethApbTop (
    .pclk_i    (pclk),
    .prstn_i   (prstn),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  readDataCheck: assert property (@(posedge pclk) disable iff (!prstn)
    (psel && penable && pready && !pwrite) |-> (prdata == expData))
  else
  begin
    $display("MISMATCH at %0t: read 0x%08h from 0x%03h, expected 0x%08h",
             $time, $sampled(prdata), $sampled(paddr[11:0]), $sampled(expData));
    $display("=== FAIL ===");
    $fatal(1, "Read data check failed");
  end

  // Whole run is about 1300 cycles, the descriptor pass alone about 1000
  always @(posedge pclk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= 4000)
    begin
      $display("Timeout after %0d cycles without finishing the tests", cycleCount);
      $display("=== FAIL ===");
      $fatal(1, "Simulation timed out");
    end
  end

  ////////////////////
  // Bus tasks
  ////////////////////
  function automatic logic [ethApbPkg::AddrWidth-1:0] wordAddr(input logic [1:0] win,
    input logic [ethApbPkg::WordIdxWidth-1:0] idx);
    return {20'h0, win, idx, 2'b00};   // win selects bits 11..10
  endfunction

  function automatic logic [ethApbPkg::DataWidth-1:0] expectedReg(
    input logic [ethApbPkg::WordIdxWidth-1:0] idx);
    return shadowReg.exists(idx) ? shadowReg[idx] : '0;
  endfunction

  task automatic apbTransfer(input logic wr, input logic [ethApbPkg::AddrWidth-1:0] addr,
    input logic [ethApbPkg::DataWidth-1:0] data, input logic [ethApbPkg::DataWidth-1:0] exp);
    @(posedge pclk);
    psel    <= 1'b1;   // Setup phase
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    expData <= exp;
    @(posedge pclk);
    penable <= 1'b1;   // Access phase
    @(posedge pclk);
    while (!pready)
      @(posedge pclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic regWrite(input logic [ethApbPkg::WordIdxWidth-1:0] idx,
    input logic [ethApbPkg::DataWidth-1:0] data);
    apbTransfer(1'b1, wordAddr(2'b00, idx), data, '0);
    case (idx)
      ethApbPkg::ModerIdx:    shadowReg[idx] = data & ethApbPkg::ModerMask;
      ethApbPkg::MacAddr1Idx: shadowReg[idx] = data & ethApbPkg::MacAddr1Mask;
      ethApbPkg::TxBdNumIdx:
        if (data <= ethApbPkg::TxBdNumMax)
          shadowReg[idx] = data;        // Larger counts leave the old value
      default:
        if (shadowReg.exists(idx))
          shadowReg[idx] = data;        // Unmapped words stay zero
    endcase
  endtask

  task automatic regCheck(input logic [ethApbPkg::WordIdxWidth-1:0] idx);
    apbTransfer(1'b0, wordAddr(2'b00, idx), '0, expectedReg(idx));
  endtask

  task automatic bdWrite(input logic [ethApbPkg::WordIdxWidth-1:0] idx,
    input logic [ethApbPkg::DataWidth-1:0] data);
    apbTransfer(1'b1, wordAddr(2'b01, idx), data, '0);
    shadowBd[idx] = data;
    bdTouched.push_back(idx);
  endtask

  task automatic bdCheck(input logic [ethApbPkg::WordIdxWidth-1:0] idx);
    apbTransfer(1'b0, wordAddr(2'b01, idx), '0, shadowBd[idx]);
  endtask

  ////////////////////
  // Test sequence
  ////////////////////
  initial
  begin
    logic [ethApbPkg::WordIdxWidth-1:0] idx;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    expData = '0;
    void'($urandom(32'h0061_b4e3));
    shadowReg[ethApbPkg::ModerIdx]    = ethApbPkg::ModerReset;
    shadowReg[ethApbPkg::TxBdNumIdx]  = ethApbPkg::TxBdNumReset;
    shadowReg[ethApbPkg::MacAddr0Idx] = '0;
    shadowReg[ethApbPkg::MacAddr1Idx] = '0;
    shadowReg[ethApbPkg::Hash0Idx]    = '0;
    shadowReg[ethApbPkg::Hash1Idx]    = '0;
    wait (prstn === 1'b1);

    foreach (shadowReg[k])
      regCheck(k);                                 // Reset values
    regCheck(8'hFF);
    for (int i = 0; i < 8; i++)
      regCheck(8'($urandom));                      // Mostly unmapped words

    for (int i = 0; i < 24; i++)
    begin
      idx = rwList[3'($urandom % 6)];
      regWrite(idx, $urandom);
      regCheck(idx);
    end

    // Descriptor count limit
    regWrite(ethApbPkg::TxBdNumIdx, ethApbPkg::TxBdNumMax);
    regCheck(ethApbPkg::TxBdNumIdx);
    regWrite(ethApbPkg::TxBdNumIdx, ethApbPkg::TxBdNumMax + 1);
    regCheck(ethApbPkg::TxBdNumIdx);
    for (int i = 0; i < 6; i++)
    begin
      regWrite(ethApbPkg::TxBdNumIdx, $urandom % 256);
      regCheck(ethApbPkg::TxBdNumIdx);
    end

    for (int i = 0; i < 128; i++)
      bdWrite(8'($urandom), $urandom);
    for (int i = 127; i >= 0; i--)
      bdCheck(bdTouched[i]);

    // Miss window aliases of a register and a descriptor
    idx = bdTouched[0];
    apbTransfer(1'b1, wordAddr(2'b10, ethApbPkg::ModerIdx), $urandom, '0);
    apbTransfer(1'b1, wordAddr(2'b11, idx), $urandom, '0);
    apbTransfer(1'b0, wordAddr(2'b10, ethApbPkg::Hash0Idx), '0, '0);
    apbTransfer(1'b0, wordAddr(2'b11, idx), '0, '0);
    foreach (shadowReg[k])
      regCheck(k);
    for (int i = 0; i < 8; i++)
      bdCheck(bdTouched[i]);

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: files.f
common/ethApbPkg.sv
common/ethRegAccessIf.sv
rtl/ethRegFile/ethRegFile.sv
rtl/ethBdMem/ethBdMem.sv
rtl/ethApbDecode.sv
rtl/ethApbTop.sv
tb/tbClkGen.sv
tb/ethApbAsserts.sv
tb/tbEthApbTop.sv

// File: run.sh
#!/bin/sh
# Build and run the Ethernet APB slave testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --assert --timing --top-module tbEthApbTop -f files.f \
  --Mdir obj_dir -o VtbEthApbTop \
  && ./obj_dir/VtbEthApbTop 2>&1 | tee sim.log
[ -f sim.log ] || { echo "Build failed"; exit 1; }
grep -q -e "=== FAIL ===" -e "%Error" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
exit 0
